// File: verilog.f
+incdir+verilog
verilog/ksWordPkg.sv
verilog/ksMicroPkg.sv
verilog/microBus.sv
verilog/controlStore.sv
verilog/feRegister.sv
verilog/shiftTiming.sv
verilog/dpShifter.sv
verilog/ksShiftUnit.sv
tb/ksShiftUnitTb.sv

// File: tb/ksShiftUnitTb.sv
`timescale 1ns/1ns

module ksShiftUnitTb import ksWordPkg::*; ();

   `include "shift_settings.svh"

   logic clk = 1'b0;
   logic rst;
   logic start;
   logic [`COUNT_WIDTH-1:0] count;
   dpWord dataIn;
   logic busy;
   logic done;
   dpWord dataOut;

   // Scoreboard state, all updated on the clock
   logic rstLast = 1'b1;
   logic pending = 1'b0;
   dpWord expWord = '0;
   int acceptCount = 0;
   int doneCount = 0;
   int errorCount = 0;

   // Operation plan, one entry per start
   int unsigned planCount[$];
   dpWord planData[$];
   int planTest[$];
   bit planBusy[$];
   bit planReady = 1'b0;
   longint unsigned watchLimit;
   string testName[1:6] = '{"reset state", "zero count", "random counts",
                            "full turns", "start while busy", "back to back"};

   ksShiftUnit dut_i (.clk(clk), .rst(rst), .start(start), .count(count),
                      .dataIn(dataIn), .busy(busy), .done(done), .dataOut(dataOut));

   // 20 ns period
   always #10 clk = ~clk;

   //////////////////////////////////////////////////
   // Reference model and helpers
   //////////////////////////////////////////////////

   // One place at a time, count taken mod the word width
   function automatic dpWord rotateLeft(input dpWord value, input int unsigned places);
      dpWord result;
      result = value;
      for (int i = 0; i < places % `WORD_WIDTH; i++)
         result = {result[`WORD_WIDTH-2:0], result[`WORD_WIDTH-1]};
      return result;
   endfunction

   function automatic dpWord randomWord();
      return dpWord'({$urandom(), $urandom()});
   endfunction

   function automatic void addOp(input int test, input int unsigned cnt, input dpWord data,
                                 input bit busyStart);
      planTest.push_back(test);
      planCount.push_back(cnt);
      planData.push_back(data);
      planBusy.push_back(busyStart);
   endfunction

   task automatic reportMismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errorCount++;
   endtask

   task automatic reportProblem(input string what);
      $display("Error at %0t: %s", $time, what);
      errorCount++;
   endtask

   // Accepted start latches the expected word, done retires it
   always @(posedge clk)
   begin
      rstLast <= rst;
      if (!rst && start && !busy)
      begin
         expWord <= rotateLeft(dataIn, count);
         pending <= 1'b1;
         acceptCount <= acceptCount + 1;
      end
      else if (!rst && done)
      begin
         pending <= 1'b0;
         doneCount <= doneCount + 1;
      end
   end

   //////////////////////////////////////////////////
   // Checking assertions
   //////////////////////////////////////////////////

   // Quiet outputs in reset and on the first cycle after it
   resetBusy: assert property (@(posedge clk) (rst || rstLast) |-> !busy)
      else reportMismatch("busy", 0, $sampled(busy));
   resetDone: assert property (@(posedge clk) (rst || rstLast) |-> !done)
      else reportMismatch("done", 0, $sampled(done));
   resetData: assert property (@(posedge clk) (rst || rstLast) |-> dataOut == '0)
      else reportMismatch("dataOut", 0, $sampled(dataOut));

   // Result at done
   doneResult: assert property (@(posedge clk) disable iff (rst) done |-> dataOut == expWord)
      else reportMismatch("dataOut", $sampled(expWord), $sampled(dataOut));

   // Single-cycle done, inside busy
   donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else reportMismatch("done", 0, $sampled(done));
   doneWithBusy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
      else reportMismatch("busy", 1, $sampled(busy));
   // Busy drops together with done
   busyFall: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
      else reportMismatch("busy", 0, $sampled(busy));
   busyEnd: assert property (@(posedge clk) disable iff (rst) (busy && !done) |=> busy)
      else reportProblem("busy fell without a done pulse");
   doneOwned: assert property (@(posedge clk) disable iff (rst) done |-> pending)
      else reportProblem("done pulse without an accepted start");

   // Result held while idle
   outputHold: assert property (@(posedge clk) disable iff (rst) !busy |=> $stable(dataOut))
      else reportProblem("dataOut changed while the unit was idle");

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   // Second start goes out after the load edge, with fresh operands
   task automatic runOp(input int unsigned cnt, input dpWord data, input bit busyStart,
                        input int gap);
      int waitCycles;
      repeat (gap) @(posedge clk);
      start <= 1'b1;
      count <= `COUNT_WIDTH'(cnt);
      dataIn <= data;
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
      if (busyStart)
      begin
         start <= 1'b1;
         count <= `COUNT_WIDTH'($urandom());
         dataIn <= randomWord();
         @(posedge clk);
         start <= 1'b0;
      end
      waitCycles = 0;
      while (!done && waitCycles < int'(cnt) + 20)
      begin
         @(posedge clk);
         waitCycles++;
      end
      if (!done)
         reportProblem($sformatf("no done within %0d cycles, count %0d", waitCycles, cnt));
   endtask

   // Watchdog, (count + 10) cycles per operation plus reset
   initial
   begin
      wait (planReady);
      #(watchLimit);
      $display("Watchdog expired at %0t, run did not finish", $time);
      $display("Testbench failed");
      $finish;
   end

   initial
   begin
      int testErrors;
      int opsInTest;
      int testsDone;
      start = 1'b0;
      count = '0;
      dataIn = '0;
      rst = 1'b1;
      void'($urandom(32'h03639b6b));
      addOp(2, 0, randomWord(), 1'b0);
      addOp(2, 0, randomWord(), 1'b0);
      for (int i = 0; i < 12; i++)
         addOp(3, 1 + ($urandom() % 511), randomWord(), 1'b0);
      addOp(4, 36, randomWord(), 1'b0);
      addOp(4, 72, randomWord(), 1'b0);
      addOp(4, 504, randomWord(), 1'b0);
      for (int i = 0; i < 3; i++)
         addOp(5, 1 + ($urandom() % 100), randomWord(), 1'b1);
      addOp(6, 0, randomWord(), 1'b0);
      for (int i = 0; i < 3; i++)
         addOp(6, $urandom() % 41, randomWord(), 1'b0);
      watchLimit = 16 * 20;
      foreach (planCount[i])
         watchLimit += (planCount[i] + 10) * 20;
      planReady = 1'b1;

      repeat (16) @(posedge clk);
      rst <= 1'b0;
      repeat (2) @(posedge clk);
      $display("Test 1 %s: %0d errors", testName[1], errorCount);
      testsDone = 1;
      testErrors = errorCount;
      opsInTest = 0;

      for (int i = 0; i < planCount.size(); i++)
      begin
         runOp(planCount[i], planData[i], planBusy[i], (planTest[i] == 6) ? 0 : 2);
         opsInTest++;
         if (i == planCount.size() - 1 || planTest[i+1] != planTest[i])
         begin
            $display("Test %0d %s: %0d operations, %0d errors", planTest[i],
                     testName[planTest[i]], opsInTest, errorCount - testErrors);
            testsDone++;
            testErrors = errorCount;
            opsInTest = 0;
         end
      end
      repeat (4) @(posedge clk);

      // One done per accepted start
      doneMatch: assert (doneCount == acceptCount)
         else reportProblem($sformatf("%0d done pulses for %0d accepted starts",
                                      doneCount, acceptCount));
      $display("Tests %0d, operations %0d, errors %0d", testsDone, planCount.size(), errorCount);
      if (errorCount == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: verilog/ksShiftUnit.sv
`timescale 1ns/1ns

`include "shift_settings.svh"

module ksShiftUnit import ksWordPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  logic [`COUNT_WIDTH-1:0] count,
   input  dpWord                   dataIn,
   output logic                    busy,
   output logic                    done,
   output dpWord                   dataOut
);

   //////////////////////////////////////////////////
   // Stage wiring
   //////////////////////////////////////////////////

   // Microword and clock enables shared by all stages
   microBus uBus ();

   // Microsequencer, start/busy/done live here
   controlStore storeStage
   (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .busy  (busy),
      .done  (done),
      .bus   (uBus.store)
   );

   // FE, takes the count at load time
   feRegister feStage
   (
      .clk   (clk),
      .rst   (rst),
      .count (count),
      .bus   (uBus.fe)
   );

   // Clock enable generation
   shiftTiming timingStage
   (
      .clk (clk),
      .rst (rst),
      .bus (uBus.timing)
   );

   // Rotating word
   dpShifter dpStage
   (
      .clk     (clk),
      .rst     (rst),
      .dataIn  (dataIn),
      .dataOut (dataOut),
      .bus     (uBus.dp)
   );

endmodule

// File: verilog/dpShifter.sv
`timescale 1ns/1ns

module dpShifter import ksWordPkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  dpWord dataIn,
   output dpWord dataOut,
   microBus.dp   bus
);

   `include "shift_settings.svh"

   //////////////////////////////////////////////////
   // Datapath register
   //////////////////////////////////////////////////

   dpWord shiftReg;
   dpWord rotLeft;
   dpWord rotRight;

   // One place left, MSB wraps into bit 0
   assign rotLeft = {shiftReg[`WORD_WIDTH-2:0], shiftReg[`WORD_WIDTH-1]};

   // Operand staged one place right
   // The fast shift enables the datapath for count+1 cycles,
   // FE runs from -count-1 up to -1, so one extra left step undoes this
   assign rotRight = {dataIn[0], dataIn[`WORD_WIDTH-1:1]};

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         shiftReg <= '0;
      else if (bus.clkenDP)
      begin
         if (bus.word.dpLoad)
            shiftReg <= rotRight;
         // One place per enabled shift cycle
         else if (bus.word.multiShift)
            shiftReg <= rotLeft;
      end
   end

   // Result stays put between operations
   assign dataOut = shiftReg;

endmodule

// File: verilog/shiftTiming.sv
`timescale 1ns/1ns

module shiftTiming
(
   input  logic clk,
   input  logic rst,
   microBus.timing bus
);

   //////////////////////////////////////////////////
   // Fast shift timing
   //////////////////////////////////////////////////

   // Set on every cycle that sits in the shift word with FE negative
   logic shiftDone;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         shiftDone <= 1'b0;
      else
         shiftDone <= bus.word.multiShift & bus.feSign;
   end

   //////////////////////////////////////////////////
   // Clock enables
   //////////////////////////////////////////////////

   // Sequencer parks on the shift word while FE is negative
   assign bus.clkenCR = ~(bus.word.multiShift & bus.feSign);

   // Datapath stops once FE turns non-negative
   // Also blocked on the cycle the sequencer is released after a shift
   assign bus.clkenDP = ~((bus.word.multiShift & ~bus.feSign) |
                          (shiftDone & bus.clkenCR));

   // A parked sequencer still sees the shift word next cycle
   crHoldInShift: assert property (@(posedge clk) disable iff (rst)
      !bus.clkenCR |=> bus.word.multiShift);

endmodule

// File: verilog/feRegister.sv
`timescale 1ns/1ns

`include "shift_settings.svh"

module feRegister import ksWordPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`COUNT_WIDTH-1:0] count,
   microBus.fe                     bus
);

   //////////////////////////////////////////////////
   // Floating exponent register
   //////////////////////////////////////////////////

   feValue fe;
   logic   feNeg;

   assign feNeg = fe[`FE_WIDTH-1];

   // Load takes -count-1
   // Count is zero extended first, so the result is always negative
   // Zero count lands on all ones
   // During the shift FE steps up once per cycle until it reaches zero
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         fe <= '0;
      else if (bus.word.feLoad)
         fe <= -feValue'(count) - feValue'(1);
      else if (bus.word.multiShift && feNeg)
         fe <= fe + feValue'(1);
   end

   // Sign goes to the timing block
   assign bus.feSign = feNeg;

   // Counting stops once FE is no longer negative
   // Holds until the next load
   feHoldsAtZero: assert property (@(posedge clk) disable iff (rst)
      (bus.word.multiShift && !feNeg) |=> (fe == $past(fe)));

endmodule

// File: verilog/controlStore.sv
`timescale 1ns/1ns

module controlStore import ksMicroPkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic start,
   output logic busy,
   output logic done,
   microBus.store bus
);

   `include "shift_settings.svh"

   //////////////////////////////////////////////////
   // Microprogram ROM
   //////////////////////////////////////////////////

   // Indexed by microaddress, in order idle, load, shift, finish
   localparam microWord microProgram [`CROM_DEPTH] = '{
      // Idle, waits for start
      '{multiShift: 1'b0, feLoad: 1'b0, dpLoad: 1'b0, finish: 1'b0, next: uaLoad},
      // Load FE and the datapath together
      '{multiShift: 1'b0, feLoad: 1'b1, dpLoad: 1'b1, finish: 1'b0, next: uaShift},
      // Fast shift, sequencer parks here while FE < 0
      '{multiShift: 1'b1, feLoad: 1'b0, dpLoad: 1'b0, finish: 1'b0, next: uaFinish},
      // Report and return
      '{multiShift: 1'b0, feLoad: 1'b0, dpLoad: 1'b0, finish: 1'b1, next: uaIdle}
   };

   //////////////////////////////////////////////////
   // Microsequencer
   //////////////////////////////////////////////////

   microAddr addr;

   // Address register
   // Advances only on CR-enabled cycles
   // Idle needs start before it moves on
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         addr <= uaIdle;
      else if (bus.clkenCR)
      begin
         if (addr != uaIdle || start)
            addr <= bus.word.next;
      end
   end

   // ROM read, word valid in the same cycle as its address
   assign bus.word = microProgram[addr];

   // Anything but idle counts as busy
   // Start is dropped while busy since the idle test fails
   assign busy = (addr != uaIdle);
   assign done = bus.word.finish;

   // Address never leaves the programmed range
   addrInRange: assert property (@(posedge clk) disable iff (rst)
      !$isunknown(addr) && (int'(addr) < `CROM_DEPTH));

endmodule

// File: verilog/microBus.sv
`timescale 1ns/1ns

interface microBus import ksMicroPkg::*; ();

   // Current microword, straight out of the control store
   microWord word;
   // FE sign bit
   logic feSign;
   // Microsequencer clock enable
   logic clkenCR;
   // Datapath clock enable
   logic clkenDP;

   // Control store, drives the microword
   modport store (output word, input clkenCR);

   // FE register, reports its sign
   modport fe (input word, output feSign);

   // Fast-shift timing, owns both clock enables
   modport timing (input word, input feSign, output clkenCR, output clkenDP);

   // Datapath, listens only
   modport dp (input word, input clkenDP);

endinterface

// File: verilog/ksMicroPkg.sv
package ksMicroPkg;

   `include "shift_settings.svh"

   //////////////////////////////////////////////////
   // Microcode types
   //////////////////////////////////////////////////

   // Control-store address
   typedef logic [$clog2(`CROM_DEPTH)-1:0] microAddr;

   // One microword
   // Only the fields this slice of the machine decodes
   typedef struct packed {
      // Fast shift cycle, held while FE is negative
      logic     multiShift;
      // Load FE from the shift count
      logic     feLoad;
      // Load the datapath from the operand
      logic     dpLoad;
      // Pulse done
      logic     finish;
      // Following microaddress
      microAddr next;
   } microWord;

   // Microaddress names
   localparam microAddr uaIdle   = microAddr'(0);
   localparam microAddr uaLoad   = microAddr'(1);
   localparam microAddr uaShift  = microAddr'(2);
   localparam microAddr uaFinish = microAddr'(3);

endpackage

// File: verilog/ksWordPkg.sv
package ksWordPkg;

   `include "shift_settings.svh"

   //////////////////////////////////////////////////
   // Datapath types
   //////////////////////////////////////////////////

   // One datapath word
   // Bit 0 is the LSB here, unlike the DEC numbering
   typedef logic [`WORD_WIDTH-1:0] dpWord;

   // FE contents
   // Signed, so the top bit is the fast-shift sign
   // Holds -count-1 after a load and counts up toward zero
   typedef logic signed [`FE_WIDTH-1:0] feValue;

endpackage

// File: verilog/shift_settings.svh
`ifndef SHIFT_SETTINGS_SVH
`define SHIFT_SETTINGS_SVH

//////////////////////////////////////////////////
// Multi-shift unit sizing
//////////////////////////////////////////////////

// Datapath word, one full 36-bit machine word
`define WORD_WIDTH 36

// FE register, two's complement
// One bit wider than the count so that -count-1 stays negative
`define FE_WIDTH 10

// External shift count
`define COUNT_WIDTH 9

// Microprogram words: idle, load, shift, finish
`define CROM_DEPTH 4

`endif
